/* logic/soc_pkg.sv */
package soc_pkg;

  // bus side widths
  typedef logic [31:0] bus_addr_t;   // byte address from the master
  typedef logic [31:0] bus_data_t;   // read / write data word
  typedef logic [3:0]  byte_en_t;    // one enable per byte lane

  // decode fields cut out of bus_addr_t
  typedef logic [15:0] page_t;       // address[31:16], picks the region
  typedef logic [13:0] word_addr_t;  // address[15:2], word offset in region

  // interrupt and hid payloads
  typedef logic [31:0] irq_vec_t;    // pending bits
  typedef logic [31:0] hid_frame_t;  // serial shift word

  // address map, one 64 KB page per region
  localparam page_t PAGE_SRAM = 16'h0200;
  localparam page_t PAGE_IRQ  = 16'h0202;
  localparam page_t PAGE_HID  = 16'h0207;

  // pending bit positions
  // bits 0 and 1 stay reserved (no timer / uart here)
  localparam int IRQ_HID   = 2;
  localparam int IRQ_AUDIO = 3;

  // hid frame layout
  // low bits are payload, parity sits above them at bit 28
  localparam int HID_PARITY_BITS = 25;  // bits covered by the xor
  localparam int HID_PARITY_POS  = 28;  // expected parity bit

endpackage

/* logic/bus_decoder.sv */
`timescale 1ns/1ps

module bus_decoder
  import soc_pkg::*;
(
  input  bus_addr_t  address,
  input  logic       read,
  input  logic       write,
  output logic       sram_read,
  output logic       sram_write,
  output logic       irq_clear,
  output logic       hid_read,
  output word_addr_t word_addr,
  input  bus_data_t  sram_readdata,
  input  bus_data_t  irq_readdata,
  input  bus_data_t  hid_readdata,
  input  logic       sram_wait,
  output bus_data_t  readdata,
  output logic       waitrequest
);

  page_t page;       // upper half of the address
  logic  sram_sel;
  logic  irq_sel;
  logic  hid_sel;

  assign page      = address[31:16];
  assign word_addr = address[15:2];  // byte lanes come from byteenable

  // region selects
  assign sram_sel = (page == PAGE_SRAM);
  assign irq_sel  = (page == PAGE_IRQ);
  assign hid_sel  = (page == PAGE_HID);

  // per-slave strobes, only the selected slave sees read/write
  assign sram_read  = sram_sel & read;
  assign sram_write = sram_sel & write;
  assign irq_clear  = irq_sel & write & (word_addr == '0);  // clear reg at offset 0
  assign hid_read   = hid_sel & read;  // read also consumes the frame

  // read data: or of selected slaves, unmapped reads zero
  assign readdata = (sram_sel ? sram_readdata : '0) |
                    (irq_sel  ? irq_readdata  : '0) |
                    (hid_sel  ? hid_readdata  : '0);

  // only sram ever stalls
  assign waitrequest = sram_sel ? sram_wait : 1'b0;

endmodule

/* logic/main_sram.sv */
`timescale 1ns/1ps

module main_sram
  import soc_pkg::*;
#(
  parameter int SRAM_WORDS = 512
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       sram_read,
  input  logic       sram_write,
  input  word_addr_t word_addr,
  input  bus_data_t  writedata,
  input  byte_en_t   byteenable,
  output bus_data_t  sram_readdata,
  output logic       sram_wait
);

  localparam int IDX_W = $clog2(SRAM_WORDS);

  bus_data_t        mem [SRAM_WORDS];
  logic [IDX_W-1:0] mem_idx;    // offset folded into the array
  logic             read_ack;   // set once read data has been registered

  assign mem_idx = IDX_W'(word_addr % SRAM_WORDS);  // wraps at SRAM_WORDS

  // write only the enabled lanes, registered read
  always_ff @(posedge clk) begin
    if (sram_write) begin
      for (int b = 0; b < 4; b++) begin
        if (byteenable[b]) mem[mem_idx][8*b +: 8] <= writedata[8*b +: 8];
      end
    end
    if (sram_read) sram_readdata <= mem[mem_idx];  // valid from next cycle
  end

  // ack sets after the first read cycle
  // drops one cycle after read goes away
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      read_ack <= 1'b0;
    end else begin
      if (sram_read && !read_ack) read_ack <= 1'b1;
      else if (!sram_read && read_ack) read_ack <= 1'b0;
    end
  end

  assign sram_wait = sram_read & ~read_ack;  // exactly one wait cycle

endmodule

/* logic/irq_ctrl.sv */
`timescale 1ns/1ps

module irq_ctrl
  import soc_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      irq_clear,
  input  bus_data_t writedata,
  input  logic      hid_strobe_pulse,
  input  logic      audio_req,
  output bus_data_t irq_readdata,
  output logic      irq_req
);

  irq_vec_t pending;
  irq_vec_t set_mask;    // sources firing this cycle
  irq_vec_t clr_mask;    // write-one-to-clear bits
  logic     audio_req_d; // last audio level
  logic     audio_rise;

  // audio is a square level, only its rising edge counts
  assign audio_rise = audio_req & ~audio_req_d;

  always_comb begin
    set_mask = '0;
    set_mask[IRQ_HID]   = hid_strobe_pulse;  // already a single pulse
    set_mask[IRQ_AUDIO] = audio_rise;
  end

  assign clr_mask = irq_clear ? irq_vec_t'(writedata) : '0;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pending     <= '0;
      audio_req_d <= 1'b0;
    end else begin
      audio_req_d <= audio_req;
      pending     <= (pending & ~clr_mask) | set_mask;  // new set beats clear
    end
  end

  assign irq_readdata = bus_data_t'(pending);
  assign irq_req      = |pending;  // any pending bit

endmodule

/* logic/hid_receiver.sv */
`timescale 1ns/1ps

module hid_receiver
  import soc_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      hid_clk,
  input  logic      hid_dat,
  input  logic      hid_str,
  input  logic      hid_read,
  output bus_data_t hid_readdata,
  output logic      hid_strobe_pulse
);

  logic [2:0] sync_1;     // {clk, dat, str} first stage
  logic [2:0] sync_2;     // second stage, safe to use
  logic       clk_s;
  logic       dat_s;
  logic       str_s;
  logic       clk_s_d;    // previous synchronized levels for edges
  logic       str_s_d;
  logic       clk_rise;
  logic       str_rise;
  hid_frame_t frame;
  logic       parity_ok;
  logic       arrived;

  // two-flop synchronizers, all three lines see the same delay
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      sync_1  <= '0;
      sync_2  <= '0;
      clk_s_d <= 1'b0;
      str_s_d <= 1'b0;
    end else begin
      sync_1  <= {hid_clk, hid_dat, hid_str};
      sync_2  <= sync_1;
      clk_s_d <= clk_s;
      str_s_d <= str_s;
    end
  end

  assign clk_s = sync_2[2];
  assign dat_s = sync_2[1];
  assign str_s = sync_2[0];

  assign clk_rise = clk_s & ~clk_s_d;
  assign str_rise = str_s & ~str_s_d;

  // lsb first, new bit enters at the top
  // xor of payload bits must match the parity slot
  assign parity_ok = (^frame[HID_PARITY_BITS-1:0]) == frame[HID_PARITY_POS];

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      frame   <= '0;
      arrived <= 1'b0;
    end else begin
      if (clk_rise) frame <= {dat_s, frame[31:1]};
      if (hid_read) arrived <= 1'b0;  // read consumes the frame
      if (str_rise && parity_ok) arrived <= 1'b1;  // new frame wins over read
    end
  end

  assign hid_readdata     = arrived ? bus_data_t'(frame) : '0;
  assign hid_strobe_pulse = str_rise;  // irq on every strobe, good parity or not

endmodule

/* logic/audio_rate_gen.sv */
`timescale 1ns/1ps

module audio_rate_gen
  import soc_pkg::*;
#(
  parameter int AUDIO_HALF_PERIOD = 567
) (
  input  logic clk,
  input  logic reset_n,
  output logic audio_req
);

  localparam int CNT_W = $clog2(AUDIO_HALF_PERIOD + 1);

  logic [CNT_W-1:0] count;

  // counts 0..AUDIO_HALF_PERIOD, flips the request level on wrap
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      count     <= '0;
      audio_req <= 1'b0;
    end else if (count == CNT_W'(AUDIO_HALF_PERIOD)) begin
      count     <= '0;
      audio_req <= ~audio_req;  // half of one sample period
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

/* logic/soc_top.sv */
`timescale 1ns/1ps

module soc_top
  import soc_pkg::*;
#(
  parameter int SRAM_WORDS        = 512,
  parameter int AUDIO_HALF_PERIOD = 567
) (
  input  logic      clk,
  input  logic      reset_n,
  input  bus_addr_t address,
  input  logic      read,
  input  logic      write,
  input  bus_data_t writedata,
  input  byte_en_t  byteenable,
  output bus_data_t readdata,
  output logic      waitrequest,
  output logic      irq_req,
  input  logic      hid_clk,
  input  logic      hid_dat,
  input  logic      hid_str
);

  // decoder to slaves
  logic       sram_read;
  logic       sram_write;
  logic       irq_clear;
  logic       hid_read;
  word_addr_t word_addr;

  // slaves back to decoder
  bus_data_t  sram_readdata;
  bus_data_t  irq_readdata;
  bus_data_t  hid_readdata;
  logic       sram_wait;

  // interrupt sources
  logic       hid_strobe_pulse;
  logic       audio_req;

  bus_decoder i_bus_decoder (
    .address       (address),
    .read          (read),
    .write         (write),
    .sram_read     (sram_read),
    .sram_write    (sram_write),
    .irq_clear     (irq_clear),
    .hid_read      (hid_read),
    .word_addr     (word_addr),
    .sram_readdata (sram_readdata),
    .irq_readdata  (irq_readdata),
    .hid_readdata  (hid_readdata),
    .sram_wait     (sram_wait),
    .readdata      (readdata),
    .waitrequest   (waitrequest)
  );

  main_sram #(.SRAM_WORDS(SRAM_WORDS)) i_main_sram (
    .clk           (clk),
    .reset_n       (reset_n),
    .sram_read     (sram_read),
    .sram_write    (sram_write),
    .word_addr     (word_addr),
    .writedata     (writedata),
    .byteenable    (byteenable),
    .sram_readdata (sram_readdata),
    .sram_wait     (sram_wait)
  );

  irq_ctrl i_irq_ctrl (
    .clk              (clk),
    .reset_n          (reset_n),
    .irq_clear        (irq_clear),
    .writedata        (writedata),   // clear mask
    .hid_strobe_pulse (hid_strobe_pulse),
    .audio_req        (audio_req),
    .irq_readdata     (irq_readdata),
    .irq_req          (irq_req)
  );

  hid_receiver i_hid_receiver (
    .clk              (clk),
    .reset_n          (reset_n),
    .hid_clk          (hid_clk),
    .hid_dat          (hid_dat),
    .hid_str          (hid_str),
    .hid_read         (hid_read),
    .hid_readdata     (hid_readdata),
    .hid_strobe_pulse (hid_strobe_pulse)
  );

  audio_rate_gen #(.AUDIO_HALF_PERIOD(AUDIO_HALF_PERIOD)) i_audio_rate_gen (
    .clk       (clk),
    .reset_n   (reset_n),
    .audio_req (audio_req)
  );

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 100
) (
  output logic clk
);

  // free running, starts low
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;  // half period each phase
  end

endmodule

/* tests/soc_top_tb.sv */
`timescale 1ns/1ps

module soc_top_tb
  import soc_pkg::*;
();

  localparam int AUDIO_HALF      = 8;      // short audio period for simulation
  localparam int HID_HALF_BIT    = 3;      // clk cycles per hid_clk phase
  localparam int READ_WAIT_LIMIT = 8;      // stuck waitrequest guard
  localparam int POLL_LIMIT      = 30;     // irq polls, about 60 cycles > one audio period
  localparam int WATCHDOG_CYCLES = 3000;   // two hid frames ~420 cycles, rest < 300

  localparam bus_addr_t SRAM_BASE     = {PAGE_SRAM, 16'h0000};
  localparam bus_addr_t IRQ_ADDR      = {PAGE_IRQ, 16'h0000};   // clear reg at offset 0
  localparam bus_addr_t HID_ADDR      = {PAGE_HID, 16'h0000};
  localparam bus_addr_t UNMAPPED_ADDR = 32'h0300_0000;          // no region here
  localparam bus_data_t AUDIO_BIT     = 32'h1 << IRQ_AUDIO;
  localparam bus_data_t HID_BIT       = 32'h1 << IRQ_HID;

  logic       clk;
  logic       reset_n;
  bus_addr_t  address;
  logic       read;
  logic       write;
  bus_data_t  writedata;
  byte_en_t   byteenable;
  bus_data_t  readdata;
  logic       waitrequest;
  logic       irq_req;
  logic       hid_clk;
  logic       hid_dat;
  logic       hid_str;

  integer     seed = 32'h90a1;
  bus_data_t  sram_model [8];  // expected contents of words 0..7
  bus_data_t  rdata;
  bus_data_t  wdata;
  byte_en_t   be;
  hid_frame_t frame;
  int         waits;

  tb_clock_gen #(.PERIOD_NS(100)) i_tb_clock_gen (.clk(clk));

  soc_top #(.AUDIO_HALF_PERIOD(AUDIO_HALF)) i_soc_top (
    .clk         (clk),
    .reset_n     (reset_n),
    .address     (address),
    .read        (read),
    .write       (write),
    .writedata   (writedata),
    .byteenable  (byteenable),
    .readdata    (readdata),
    .waitrequest (waitrequest),
    .irq_req     (irq_req),
    .hid_clk     (hid_clk),
    .hid_dat     (hid_dat),
    .hid_str     (hid_str)
  );

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_mismatch(input string test_name, input bus_data_t expected,
                                 input bus_data_t actual);
    stop_on_failure($sformatf("error: %s expected %h actual %h", test_name, expected, actual));
  endtask

  // an sram read stalls for a single cycle only
  assert property (@(posedge clk) disable iff (!reset_n) waitrequest |=> !waitrequest)
    else stop_on_failure("waitrequest stayed high for more than one cycle");

  // single cycle write, master drops write on the next edge
  task automatic bus_write(input bus_addr_t addr, input bus_data_t data, input byte_en_t en);
    @(posedge clk);
    address    <= addr;
    writedata  <= data;
    byteenable <= en;
    write      <= 1'b1;
    @(posedge clk);
    write <= 1'b0;
  endtask

  // hold read until waitrequest drops, count the stalled cycles
  task automatic bus_read(input bus_addr_t addr, output bus_data_t data, output int stalls);
    stalls = 0;
    @(posedge clk);
    address <= addr;
    read    <= 1'b1;
    @(negedge clk);  // outputs settled mid cycle
    while (waitrequest) begin
      stalls++;
      if (stalls > READ_WAIT_LIMIT) stop_on_failure("read never completed, waitrequest stuck");
      @(negedge clk);
    end
    data = readdata;
    @(posedge clk);
    read <= 1'b0;  // at least one idle cycle before the next read
  endtask

  // lsb first, each level held long enough for the synchronizers
  task automatic send_hid_frame(input hid_frame_t bits);
    @(posedge clk);
    for (int i = 0; i < 32; i++) begin
      hid_clk <= 1'b0;
      hid_dat <= bits[i];
      repeat (HID_HALF_BIT) @(posedge clk);
      hid_clk <= 1'b1;  // receiver shifts on this edge
      repeat (HID_HALF_BIT) @(posedge clk);
    end
    hid_clk <= 1'b0;
    repeat (HID_HALF_BIT) @(posedge clk);
    hid_str <= 1'b1;
    repeat (HID_HALF_BIT) @(posedge clk);
    hid_str <= 1'b0;
    repeat (HID_HALF_BIT + 2) @(posedge clk);  // let arrived and pending settle
  endtask

  // lanes with enable set take the new byte
  function automatic bus_data_t merge_bytes(input bus_data_t old_word, input bus_data_t new_word,
                                            input byte_en_t en);
    bus_data_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (en[b]) merged[8*b +: 8] = new_word[8*b +: 8];
    end
    return merged;
  endfunction

  // parity slot = xor of the payload, flipped for a bad frame
  function automatic hid_frame_t build_hid_frame(input logic [31:0] raw, input logic good);
    hid_frame_t f;
    f = raw;
    f[HID_PARITY_POS] = (^raw[HID_PARITY_BITS-1:0]) ^ ~good;
    return f;
  endfunction

  // returns once bit 3 has gone from clear to set, so the audio phase is known
  task automatic wait_audio_pending(output bus_data_t pending);
    logic seen_clear;
    int   stalls;
    seen_clear = 1'b0;
    for (int i = 0; i < POLL_LIMIT; i++) begin
      bus_read(IRQ_ADDR, pending, stalls);
      if (!pending[IRQ_AUDIO]) seen_clear = 1'b1;
      else if (seen_clear) return;
      else bus_write(IRQ_ADDR, AUDIO_BIT, 4'hf);  // old edge, knock it down first
    end
    stop_on_failure("audio interrupt bit 3 did not set within the poll limit");
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_on_failure("watchdog expired before the tests finished");
  end

  initial begin
    reset_n    = 1'b0;
    address    = '0;
    read       = 1'b0;
    write      = 1'b0;
    writedata  = '0;
    byteenable = '0;
    hid_clk    = 1'b0;
    hid_dat    = 1'b0;
    hid_str    = 1'b0;
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;

    // quiet after reset and an unmapped page reads zero
    @(negedge clk);
    assert (irq_req == 1'b0) else report_mismatch("reset irq_req", 0, irq_req);
    assert (waitrequest == 1'b0) else report_mismatch("reset waitrequest", 0, waitrequest);
    bus_read(UNMAPPED_ADDR, rdata, waits);
    assert (rdata == '0) else report_mismatch("unmapped read data", 0, rdata);
    assert (waits == 0) else report_mismatch("unmapped read waits", 0, waits);

    // sram full words first then random partial lanes
    for (int i = 0; i < 8; i++) begin
      wdata = $random(seed);
      bus_write(SRAM_BASE + 4 * i, wdata, 4'hf);
      sram_model[i] = wdata;
    end
    for (int i = 0; i < 8; i++) begin
      wdata = $random(seed);
      be    = $random(seed);
      bus_write(SRAM_BASE + 4 * i, wdata, be);
      sram_model[i] = merge_bytes(sram_model[i], wdata, be);
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(SRAM_BASE + 4 * i, rdata, waits);
      assert (waits == 1) else report_mismatch("sram read wait cycles", 1, waits);
      assert (rdata == sram_model[i]) else report_mismatch("sram readback", sram_model[i], rdata);
    end

    // good parity frame is read once and then consumed
    frame = build_hid_frame($random(seed), 1'b1);
    send_hid_frame(frame);
    bus_read(HID_ADDR, rdata, waits);
    assert (rdata == frame) else report_mismatch("hid good frame", frame, rdata);
    assert (waits == 0) else report_mismatch("hid read waits", 0, waits);
    bus_read(HID_ADDR, rdata, waits);
    assert (rdata == '0) else report_mismatch("hid second read", 0, rdata);

    // bad parity gives no data but the irq still fires
    bus_write(IRQ_ADDR, HID_BIT, 4'hf);
    frame = build_hid_frame($random(seed), 1'b0);
    send_hid_frame(frame);
    bus_read(HID_ADDR, rdata, waits);
    assert (rdata == '0) else report_mismatch("hid bad parity read", 0, rdata);
    bus_read(IRQ_ADDR, rdata, waits);
    assert (rdata[IRQ_HID]) else report_mismatch("hid bad parity irq bit", HID_BIT, rdata);

    // audio sets bit 3 and a clear hits only the written bits
    wait_audio_pending(rdata);
    assert (rdata == (AUDIO_BIT | HID_BIT))
      else report_mismatch("irq audio set", AUDIO_BIT | HID_BIT, rdata);
    @(negedge clk);
    assert (irq_req) else stop_on_failure("irq_req low while bits are pending");
    bus_write(IRQ_ADDR, AUDIO_BIT, 4'hf);
    bus_read(IRQ_ADDR, rdata, waits);
    assert (rdata == HID_BIT) else report_mismatch("irq clear bit 3 only", HID_BIT, rdata);
    wait_audio_pending(rdata);  // next audio rising edge
    assert (rdata == (AUDIO_BIT | HID_BIT))
      else report_mismatch("irq audio set again", AUDIO_BIT | HID_BIT, rdata);
    bus_write(IRQ_ADDR, AUDIO_BIT | HID_BIT, 4'hf);
    bus_read(IRQ_ADDR, rdata, waits);
    assert (rdata == '0) else report_mismatch("irq clear all", 0, rdata);
    @(negedge clk);
    assert (irq_req == 1'b0) else report_mismatch("irq_req after clear", 0, irq_req);

    $display("NO ERRORS");
    $finish;
  end

endmodule

/* soc_top.f */
logic/soc_pkg.sv
logic/bus_decoder.sv
logic/main_sram.sv
logic/irq_ctrl.sv
logic/hid_receiver.sv
logic/audio_rate_gen.sv
logic/soc_top.sv
tests/tb_clock_gen.sv
tests/soc_top_tb.sv

/* Bender.yml */
package:
  name: soc_top

sources:
  - logic/soc_pkg.sv
  - logic/bus_decoder.sv
  - logic/main_sram.sv
  - logic/irq_ctrl.sv
  - logic/hid_receiver.sv
  - logic/audio_rate_gen.sv
  - logic/soc_top.sv
  - target: test
    files:
      - tests/tb_clock_gen.sv
      - tests/soc_top_tb.sv
